// File: sources.f
+incdir+tests
src/mac_rx_pkg.sv
src/rx_input_stage.sv
src/rx_frame_ctrl.sv
src/mac_crc.sv
src/rx_stream_out.sv
src/mac_rx_top.sv
tests/tb_mac_rx.sv

// File: Makefile
SIM := obj_dir/Vtb_mac_rx

$(SIM): sources.f $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_mac_rx -o Vtb_mac_rx

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: tests/tb_frame_tasks.svh
// reference crc-32, burst builder and byte drivers for the mac receive testbench
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// bitwise 802.3 crc step, reflected register, lsb of the byte goes first
function automatic logic [31:0] crc32_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
        r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
    end
    return r;
endfunction

function automatic int random_payload_len();
    return 46 + int'($urandom % 35);             // 46 .. 80 bytes
endfunction

// preamble, sfd, random payload and fcs into burst_q
task automatic build_burst(input int pay_len, input int flip_idx);
    logic [31:0] crc;
    logic [7:0]  b;
    crc = 32'hFFFF_FFFF;
    burst_q.delete();
    for (int i = 0; i < PREAMBLE_LEN; i++) burst_q.push_back(PREAMBLE_BYTE);
    burst_q.push_back(SFD_BYTE);
    for (int i = 0; i < pay_len; i++) begin
        b = 8'($urandom);
        burst_q.push_back(b);
        crc = crc32_step(crc, b);
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) burst_q.push_back(crc[8*i +: 8]);  // fcs, low byte first
    // one flipped bit breaks the preamble, the sfd or the fcs
    if (flip_idx >= 0) burst_q[flip_idx] = burst_q[flip_idx] ^ 8'h01;
endtask

// one byte 2 ns after the edge, with the output slot expected for it
task automatic drive_cycle(input rx_byte_t b, input mac_stream_t e);
    exp_t x;
    @(posedge mac_rx_clk);
    #2;
    rx_byte_i = b;
    if (!b.dv && !b.err) begin                   // plain idle
        exp_status.duplex = b.data[3];           // 1 - full duplex
        exp_status.speed  = b.data[2:1];         // 10 - 1Gb, 01 - 100Mb
        exp_status.link   = b.data[0];
    end
    x.strm = e;
    x.st   = exp_status;
    exp_q.push_back(x);
endtask

task automatic drive_idle(input int n);
    rx_byte_t b;
    b           = '0;
    b.data[3:0] = idle_nibble;
    repeat (n) drive_cycle(b, '0);
endtask

// sends burst_q and queues the output stream expected for each byte
task automatic drive_burst(input int err_idx);
    rx_byte_t    b;
    mac_stream_t e;
    logic [31:0] crc;
    logic        ok;
    logic        bad;
    logic        done;
    ok   = 1'b1;
    bad  = 1'b0;
    done = 1'b0;
    crc  = 32'hFFFF_FFFF;
    for (int i = 0; i < burst_q.size(); i++) begin
        if (i < PREAMBLE_LEN) ok = ok && (burst_q[i] == PREAMBLE_BYTE);
        if (i == PREAMBLE_LEN) ok = ok && (burst_q[i] == SFD_BYTE);
        b.data = burst_q[i];
        b.dv   = 1'b1;
        b.err  = (i == err_idx);
        e      = '0;
        if (ok && i > PREAMBLE_LEN) begin        // frame byte
            crc     = crc32_step(crc, b.data);
            bad     = bad || b.err;
            e.data  = b.data;
            e.valid = !done;                     // nothing passed after eof
            e.sof   = (i == PREAMBLE_LEN + 1);
            e.eof   = !done && !bad && (crc == 32'hDEBB_20E3);  // reflected residue
            done    = done || e.eof;
        end
        drive_cycle(b, e);
    end
endtask

// idles the line until eof shows on the output
task automatic wait_eof(input int max_cycles);
    int n;
    n = 0;
    while (!mac_rx_o.eof) begin
        if (n == max_cycles) begin
            fail_now($sformatf("Timeout: no eof within %0d cycles", max_cycles));
        end else begin
            drive_idle(1);
            n++;
        end
    end
endtask

`endif

// File: tests/tb_mac_rx.sv
// testbench for the gigabit mac receive path: clock, reset, frame scenarios
// and per-cycle checks of the output stream and phy status
`timescale 1ns/1ps

module tb_mac_rx;
    import mac_rx_pkg::*;

    // expected output slot and status for one driven byte
    typedef struct packed {
        mac_stream_t strm;
        eth_status_t st;
    } exp_t;

    logic        mac_rx_clk = 1'b0;
    logic        reset_i;
    rx_byte_t    rx_byte_i;
    mac_stream_t mac_rx_o;
    eth_status_t eth_status_o;

    exp_t        exp_q[$];          // one entry per driven cycle
    logic [7:0]  burst_q[$];        // bytes of the next burst
    eth_status_t exp_status = '0;   // status after the last idle byte
    logic [3:0]  idle_nibble;       // status sent on idle bytes
    int          eof_cnt = 0;
    int          good_frames = 0;
    int          len;

    mac_rx_top dut0 (
        .mac_rx_clk   (mac_rx_clk),
        .reset_i      (reset_i),
        .rx_byte_i    (rx_byte_i),
        .mac_rx_o     (mac_rx_o),
        .eth_status_o (eth_status_o)
    );

    always #20 mac_rx_clk = ~mac_rx_clk;  // 40 ns period

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        fail_now($sformatf("Mismatch at %0t: %s expected %0h got %0h",
                           $time, name, exp_v, got_v));
    endtask

    `include "tb_frame_tasks.svh"

    // ----------------------------------------------------------------------------
    // output checks, 3 edges behind the input
    // ----------------------------------------------------------------------------
    always @(posedge mac_rx_clk) begin
        exp_t x;
        if (exp_q.size() > 3) begin
            x = exp_q.pop_front();
            assert (mac_rx_o.valid == x.strm.valid)
                else report_mismatch("mac_rx_o.valid", 32'(x.strm.valid), 32'(mac_rx_o.valid));
            assert (mac_rx_o.sof == x.strm.sof)
                else report_mismatch("mac_rx_o.sof", 32'(x.strm.sof), 32'(mac_rx_o.sof));
            assert (mac_rx_o.eof == x.strm.eof)
                else report_mismatch("mac_rx_o.eof", 32'(x.strm.eof), 32'(mac_rx_o.eof));
            assert (!x.strm.valid || mac_rx_o.data == x.strm.data)
                else report_mismatch("mac_rx_o.data", 32'(x.strm.data), 32'(mac_rx_o.data));
            // status lags by 2 edges only, next entry in line
            assert (eth_status_o == exp_q[0].st)
                else report_mismatch("eth_status_o", 32'(exp_q[0].st), 32'(eth_status_o));
            if (mac_rx_o.eof) eof_cnt++;
        end
    end

    // ----------------------------------------------------------------------------
    // scenarios
    // ----------------------------------------------------------------------------
    initial begin
        void'($urandom(30));
        rx_byte_i   = '0;
        reset_i     = 1'b1;
        idle_nibble = 4'h0;
        repeat (5) @(posedge mac_rx_clk);
        #2;
        reset_i = 1'b0;
        drive_idle(4);

        idle_nibble = 4'b1101;                   // full duplex, 1 Gb, link up
        drive_idle(6);
        assert (eth_status_o.link && eth_status_o.speed == 2'b10 && eth_status_o.duplex)
            else fail_now("status not decoded as link up, 1 Gb, full duplex");

        build_burst(random_payload_len(), -1);   // good frame
        drive_burst(-1);
        wait_eof(10);
        good_frames++;

        len = random_payload_len();              // last fcs byte corrupted
        build_burst(len, PREAMBLE_LEN + len + 4);
        drive_burst(-1);
        drive_idle(6);

        build_burst(random_payload_len(), 3);    // wrong preamble byte
        drive_burst(-1);
        drive_idle(4);
        build_burst(random_payload_len(), PREAMBLE_LEN);  // wrong sfd
        drive_burst(-1);
        drive_idle(4);

        build_burst(random_payload_len(), -1);   // err byte mid frame
        drive_burst(PREAMBLE_LEN + 13);
        drive_idle(6);

        idle_nibble = 4'b0011;                   // half duplex, 100 Mb, link up
        drive_idle(4);

        // back to back, minimum gap
        repeat (3) begin
            build_burst(random_payload_len(), -1);
            drive_burst(-1);
            drive_idle(2);
            good_frames++;
        end
        drive_idle(8);

        if (eof_cnt != good_frames) begin
            fail_now($sformatf("saw %0d eof strobes for %0d good frames", eof_cnt, good_frames));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: src/mac_rx_top.sv
// gigabit mac receive path: input register, frame controller,
// crc-32 checker and output stream stage
`timescale 1ns/1ps

module mac_rx_top (
    input  logic                     mac_rx_clk,
    input  logic                     reset_i,
    input  mac_rx_pkg::rx_byte_t     rx_byte_i,     // byte stream from ddr capture
    output mac_rx_pkg::mac_stream_t  mac_rx_o,      // da .. fcs, eof on good crc
    output mac_rx_pkg::eth_status_t  eth_status_o   // link, speed, duplex
);
    import mac_rx_pkg::*;

    rx_byte_t         rx_byte_q;    // registered input, read by all stages
    logic             crc_clear;
    logic             crc_en;
    logic             frame_sof;
    logic             frame_act;
    logic             frame_bad;
    logic [CRC_W-1:0] crc_value;

    // ------------------------------------------------------------------------
    // stage 1, input register and phy status
    // ------------------------------------------------------------------------
    rx_input_stage u_input_stage (
        .mac_rx_clk   (mac_rx_clk),
        .reset_i      (reset_i),
        .rx_byte_i    (rx_byte_i),
        .rx_byte_o    (rx_byte_q),
        .eth_status_o (eth_status_o)
    );

    // preamble / sfd check, strobes are combinational on rx_byte_q
    rx_frame_ctrl u_frame_ctrl (
        .mac_rx_clk  (mac_rx_clk),
        .reset_i     (reset_i),
        .rx_byte_i   (rx_byte_q),
        .crc_clear_o (crc_clear),
        .crc_en_o    (crc_en),
        .frame_sof_o (frame_sof),
        .frame_act_o (frame_act),
        .frame_bad_o (frame_bad)
    );

    mac_crc u_crc (
        .mac_rx_clk  (mac_rx_clk),
        .crc_clear_i (crc_clear),
        .crc_en_i    (crc_en),
        .data_i      (rx_byte_q.data),
        .crc_o       (crc_value)
    );

    // ------------------------------------------------------------------------
    // stages 2 and 3, crc alignment and output register
    // ------------------------------------------------------------------------
    rx_stream_out u_stream_out (
        .mac_rx_clk  (mac_rx_clk),
        .reset_i     (reset_i),
        .data_i      (rx_byte_q.data),
        .crc_i       (crc_value),
        .frame_sof_i (frame_sof),
        .frame_act_i (frame_act),
        .frame_bad_i (frame_bad),
        .mac_rx_o    (mac_rx_o)
    );

endmodule

// File: src/rx_stream_out.sv
// output stage: aligns bytes and frame flags with the crc result,
// finds the crc residue for eof and registers the receive stream
`timescale 1ns/1ps

module rx_stream_out (
    input  logic                          mac_rx_clk,
    input  logic                          reset_i,
    input  logic [7:0]                    data_i,       // registered input byte
    input  logic [mac_rx_pkg::CRC_W-1:0]  crc_i,        // one cycle behind data_i
    input  logic                          frame_sof_i,
    input  logic                          frame_act_i,
    input  logic                          frame_bad_i,
    output mac_rx_pkg::mac_stream_t       mac_rx_o
);
    import mac_rx_pkg::*;

    // align stage, same cycle as the crc that includes the byte
    logic [7:0] data_d;
    logic       sof_d;
    logic       act_d;
    logic       bad_d;

    // output registers
    logic [7:0] out_data_q;
    logic       out_valid_q;
    logic       out_sof_q;
    logic       out_eof_q;

    logic       valid_next;
    logic       eof_next;

    // ------------------------------------------------------------------------
    // align with crc
    // ------------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        data_d <= data_i;
    end

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            sof_d <= 1'b0;
            act_d <= 1'b0;
            bad_d <= 1'b0;
        end else begin
            sof_d <= frame_sof_i;
            act_d <= frame_act_i;
            bad_d <= frame_bad_i;
        end
    end

    // ------------------------------------------------------------------------
    // valid / eof
    // ------------------------------------------------------------------------
    always_comb begin
        valid_next = out_valid_q;
        if (sof_d) begin
            valid_next = 1'b1;        // frame opens on first da byte
        end else if (out_eof_q || !act_d) begin
            valid_next = 1'b0;        // closes after eof or when dv fell
        end
        // only one eof per frame, bytes after it are not passed on
        eof_next = valid_next && !bad_d && (crc_i == CRC_RESIDUE);
    end

    always_ff @(posedge mac_rx_clk) begin
        out_data_q <= data_d;
    end

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
            out_sof_q   <= 1'b0;
            out_eof_q   <= 1'b0;
        end else begin
            out_valid_q <= valid_next;
            out_sof_q   <= sof_d;
            out_eof_q   <= eof_next;
        end
    end

    assign mac_rx_o.data  = out_data_q;
    assign mac_rx_o.valid = out_valid_q;
    assign mac_rx_o.sof   = out_sof_q;
    assign mac_rx_o.eof   = out_eof_q;

endmodule

// File: src/mac_crc.sv
// ethernet crc-32 register, one byte per cycle, lsb first,
// with synchronous preset and enable
`timescale 1ns/1ps

module mac_crc (
    input  logic                           mac_rx_clk,
    input  logic                           crc_clear_i,  // load CRC_INIT
    input  logic                           crc_en_i,     // take data_i
    input  logic [7:0]                     data_i,
    output logic [mac_rx_pkg::CRC_W-1:0]   crc_o         // normal bit order
);
    import mac_rx_pkg::*;

    logic [CRC_W-1:0] crc_q;     // reflected register, bit 0 is x^31 term
    logic [CRC_W-1:0] crc_next;

    // ------------------------------------------------------------------------
    // byte update, 8 serial steps unrolled
    // ------------------------------------------------------------------------
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_i[i]) begin   // bit 0 goes on the wire first
                crc_next = (crc_next >> 1) ^ CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge mac_rx_clk) begin
        if (crc_clear_i) begin
            crc_q <= CRC_INIT;
        end else if (crc_en_i) begin
            crc_q <= crc_next;
        end
    end

    // residue compare is done in msb-first order, flip the register
    always_comb begin
        for (int b = 0; b < CRC_W; b++) begin
            crc_o[b] = crc_q[CRC_W-1-b];
        end
    end

endmodule

// File: src/rx_frame_ctrl.sv
// receive controller: preamble and sfd check, drop of bad bursts,
// crc clear/enable and frame strobes for the output stage
`timescale 1ns/1ps

module rx_frame_ctrl (
    input  logic                  mac_rx_clk,
    input  logic                  reset_i,
    input  mac_rx_pkg::rx_byte_t  rx_byte_i,     // registered input byte
    output logic                  crc_clear_o,   // preset crc, sfd cycle
    output logic                  crc_en_o,      // crc takes this byte
    output logic                  frame_sof_o,   // first accepted byte
    output logic                  frame_act_o,   // frame byte accepted
    output logic                  frame_bad_o    // err seen in this frame
);
    import mac_rx_pkg::*;

    rx_state_e            state_q;
    rx_state_e            state_d;
    logic [PRE_CNT_W-1:0] pre_cnt_q;   // preamble bytes seen so far
    logic                 sof_pend_q;  // sfd was on the previous cycle
    logic                 bad_q;
    logic                 is_pre;
    logic                 is_sfd;
    logic                 pre_done;
    logic                 sfd_hit;
    logic                 in_payload;

    assign is_pre     = (rx_byte_i.data == PREAMBLE_BYTE);
    assign is_sfd     = (rx_byte_i.data == SFD_BYTE);
    assign pre_done   = (pre_cnt_q == PRE_CNT_W'(PREAMBLE_LEN));  // sfd slot
    assign sfd_hit    = (state_q == PREAMBLE) && rx_byte_i.dv && pre_done && is_sfd;
    assign in_payload = (state_q == PAYLOAD) && rx_byte_i.dv;

    // ------------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (rx_byte_i.dv) begin
                    state_d = is_pre ? PREAMBLE : DROP;  // burst byte 0
                end
            end
            PREAMBLE: begin
                if (!rx_byte_i.dv) begin
                    state_d = IDLE;                      // burst too short
                end else if (pre_done) begin
                    state_d = is_sfd ? PAYLOAD : DROP;
                end else if (!is_pre) begin
                    state_d = DROP;
                end
            end
            PAYLOAD, DROP: begin
                if (!rx_byte_i.dv) state_d = IDLE;       // end of burst
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            state_q    <= IDLE;
            pre_cnt_q  <= '0;
            sof_pend_q <= 1'b0;
            bad_q      <= 1'b0;
        end else begin
            state_q    <= state_d;
            // counting only matters inside PREAMBLE, left at sfd slot
            pre_cnt_q  <= (state_q == PREAMBLE) ? pre_cnt_q + 1'b1 : PRE_CNT_W'(1);
            sof_pend_q <= sfd_hit;
            if (sfd_hit) begin
                bad_q <= 1'b0;                          // new frame starts clean
            end else if (in_payload && rx_byte_i.err) begin
                bad_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // strobes
    // ------------------------------------------------------------------------
    assign crc_clear_o = sfd_hit || reset_i;         // crc register has no own reset
    assign crc_en_o    = in_payload;
    assign frame_act_o = in_payload;
    assign frame_sof_o = in_payload && sof_pend_q;   // byte right after sfd
    assign frame_bad_o = bad_q || (in_payload && rx_byte_i.err);  // err byte counts too

endmodule

// File: src/rx_input_stage.sv
// input register for the received byte stream and
// decoder of the in-band phy status sent between frames
`timescale 1ns/1ps

module rx_input_stage (
    input  logic                     mac_rx_clk,
    input  logic                     reset_i,
    input  mac_rx_pkg::rx_byte_t     rx_byte_i,   // from ddr capture
    output mac_rx_pkg::rx_byte_t     rx_byte_o,   // registered byte
    output mac_rx_pkg::eth_status_t  eth_status_o
);
    import mac_rx_pkg::*;

    rx_byte_t    rx_byte_q;
    eth_status_t eth_status_q;

    // ------------------------------------------------------------------------
    // byte register
    // ------------------------------------------------------------------------
    // data is cleared too, the status decoder reads it right after reset
    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            rx_byte_q <= '0;
        end else begin
            rx_byte_q <= rx_byte_i;
        end
    end

    // ------------------------------------------------------------------------
    // in-band status
    // ------------------------------------------------------------------------
    // phy repeats link/speed/duplex on rxd[3:0] while dv and err are low
    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            eth_status_q <= '0;
        end else if (!rx_byte_q.dv && !rx_byte_q.err) begin
            eth_status_q <= eth_status_t'(rx_byte_q.data[3:0]);  // plain idle
        end
        // carrier extend / false carrier and frames keep the old status
    end

    assign rx_byte_o    = rx_byte_q;
    assign eth_status_o = eth_status_q;

endmodule

// File: src/mac_rx_pkg.sv
// shared types, controller state enum and frame / crc constants
// for the byte-level gigabit ethernet receive path
package mac_rx_pkg;

    // ------------------------------------------------------------------------
    // frame constants
    // ------------------------------------------------------------------------
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;   // each preamble byte
    localparam logic [7:0] SFD_BYTE      = 8'hD5;   // start of frame delimiter
    localparam int         PREAMBLE_LEN  = 7;       // preamble bytes before sfd

    // wide enough to count the whole preamble
    localparam int PRE_CNT_W = $clog2(PREAMBLE_LEN + 1);

    // ------------------------------------------------------------------------
    // crc-32 constants
    // ------------------------------------------------------------------------
    localparam int               CRC_W       = 32;
    localparam logic [CRC_W-1:0] CRC_INIT    = 32'hFFFF_FFFF;  // preset before frame
    localparam logic [CRC_W-1:0] CRC_POLY    = 32'hEDB8_8320;  // reflected 802.3 poly
    // register value after a good frame incl. fcs, normal bit order
    localparam logic [CRC_W-1:0] CRC_RESIDUE = 32'hC704_DD7B;

    // ------------------------------------------------------------------------
    // stream types
    // ------------------------------------------------------------------------

    // one byte from the rgmii ddr capture
    typedef struct packed {
        logic [7:0] data;
        logic       dv;     // rx_ctl rising edge half
        logic       err;    // rx_ctl falling edge half (dv xor er)
    } rx_byte_t;

    // receive stream toward the user logic
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sof;    // first destination address byte
        logic       eof;    // last fcs byte, only when crc is good
    } mac_stream_t;

    // in-band phy status, same bit order as the idle nibble
    typedef struct packed {
        logic       duplex; // 1 - full, 0 - half
        logic [1:0] speed;  // 00 - 10Mb, 01 - 100Mb, 10 - 1Gb
        logic       link;   // 1 - up
    } eth_status_t;

    // receive controller states
    typedef enum logic [1:0] {
        IDLE,       // waiting for dv
        PREAMBLE,   // counting preamble bytes, expecting sfd
        PAYLOAD,    // frame bytes accepted
        DROP        // bad preamble or sfd, wait for dv low
    } rx_state_e;

endpackage
